/* design/sd_block_config.svh */
// Build constants for the SD block device; include wherever a divider, count or address is needed
`ifndef SD_BLOCK_CONFIG_SVH
`define SD_BLOCK_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// SPI clock, clk cycles per half period
//////////////////////////////////////////////////////////////////////
`define SD_SLOW_DIV 32
`define SD_FAST_DIV 2

// Idle bytes with chip select high before CMD0
`define SD_DUMMY_BYTES 10

// 512-byte sector held as 16-bit words
`define SD_SECTOR_WORDS 256

// Wishbone word addresses
`define SD_REG_CTRL 2'd0
`define SD_REG_ADDR 2'd1
`define SD_REG_DATA 2'd2

`endif

/* design/sd_block_pkg.sv */
// Opcode and controller state types plus SD response byte values, shared by RTL and card model
package sd_block_pkg;

	// Host command opcodes, written to bits 1:0 of the control register
	typedef enum logic [1:0] {
		op_init  = 2'd0,
		op_read  = 2'd1,
		op_write = 2'd2
	} blk_op_t;

	// Card controller phases
	typedef enum logic [5:0] {
		st_idle,
		st_dummy,
		st_gap,
		st_send_cmd,
		st_poll_r1,
		st_rd_token,
		st_rd_data,
		st_rd_crc,
		st_wr_token,
		st_wr_data,
		st_wr_crc,
		st_wr_dresp,
		st_wr_busy,
		st_done
	} card_state_t;

	localparam logic [7:0] R1_IDLE        = 8'h01;
	localparam logic [7:0] R1_READY       = 8'h00;
	localparam logic [7:0] TOKEN_START    = 8'hFE;
	// Data response status field, bits 3:1
	localparam logic [2:0] DRESP_ACCEPTED = 3'b010;

endpackage

/* design/sd_block_if.sv */
// Internal links of the block device: host command port and dual-port sector RAM access
`timescale 1ns/1ps

interface blk_cmd_if;
	import sd_block_pkg::*;

	logic        start;
	blk_op_t     op;
	logic [15:0] sector;
	logic        busy;
	logic        err;
	logic        inited;

	modport host (output start, output op, output sector, input busy, input err, input inited);
	modport card (input start, input op, input sector, output busy, output err, output inited);
endinterface

interface sector_buf_if;
	// Host side port
	logic        h_we;
	logic [7:0]  h_addr;
	logic [15:0] h_wdata;
	logic [15:0] h_rdata;
	// Card side port
	logic        c_we;
	logic [7:0]  c_addr;
	logic [15:0] c_wdata;
	logic [15:0] c_rdata;

	modport host (output h_we, output h_addr, output h_wdata, input h_rdata);
	modport card (output c_we, output c_addr, output c_wdata, input c_rdata);
	modport mem (input h_we, input h_addr, input h_wdata, output h_rdata,
		input c_we, input c_addr, input c_wdata, output c_rdata);
endinterface

/* design/sector_buffer.sv */
// Dual-port sector RAM shared by the host register port and the card controller
`timescale 1ns/1ps
`include "sd_block_config.svh"

module sector_buffer (
	input logic       clk,
	sector_buf_if.mem mem
);
	logic [15:0] ram [0:`SD_SECTOR_WORDS-1];

	// Both ports synchronous, one cycle read latency
	always_ff @(posedge clk) begin
		if (mem.h_we)
			ram[mem.h_addr] <= mem.h_wdata;
		if (mem.c_we)
			ram[mem.c_addr] <= mem.c_wdata;
		mem.h_rdata <= ram[mem.h_addr];
		mem.c_rdata <= ram[mem.c_addr];
	end

endmodule

/* design/spi_byte_engine.sv */
// SPI mode-0 byte shifter with clk-derived SCLK; one go pulse exchanges one byte
`timescale 1ns/1ps
`include "sd_block_config.svh"

module spi_byte_engine (
	input  logic       clk,
	input  logic       reset,
	input  logic       go,
	input  logic       fast,
	input  logic [7:0] tx,
	input  logic       cs_on,
	input  logic       sd_miso,
	output logic [7:0] rx,
	output logic       done,
	output logic       sd_cs_n,
	output logic       sd_sclk,
	output logic       sd_mosi
);
	logic       active;
	logic       tick;
	logic [7:0] div_cnt;
	logic [7:0] half_top;
	logic [3:0] edge_cnt;
	logic [7:0] tx_sh;

	assign half_top = fast ? 8'(`SD_FAST_DIV - 1) : 8'(`SD_SLOW_DIV - 1);
	// End of an SCLK half period
	assign tick     = active && (div_cnt == half_top);
	assign sd_mosi  = tx_sh[7];
	assign sd_cs_n  = !cs_on;

	always_ff @(posedge clk) begin
		if (reset) begin
			active   <= 1'b0;
			div_cnt  <= 8'd0;
			edge_cnt <= 4'd0;
			sd_sclk  <= 1'b0;
			done     <= 1'b0;
			tx_sh    <= 8'hFF;
		end else begin
			done <= 1'b0;
			if (go && !active) begin
				active   <= 1'b1;
				div_cnt  <= 8'd0;
				edge_cnt <= 4'd0;
				tx_sh    <= tx;
			end else if (tick) begin
				div_cnt  <= 8'd0;
				sd_sclk  <= !sd_sclk;
				edge_cnt <= edge_cnt + 4'd1;
				// Sample on rising edge, shift out on falling edge
				if (!sd_sclk)
					rx <= {rx[6:0], sd_miso};
				else
					tx_sh <= {tx_sh[6:0], 1'b1};
				// 16 edges make one byte
				if (edge_cnt == 4'd15) begin
					active <= 1'b0;
					done   <= 1'b1;
				end
			end else if (active) begin
				div_cnt <= div_cnt + 8'd1;
			end
		end
	end

endmodule

/* design/card_ctrl.sv */
// SD card sequencer over SPI: card reset, single-block read and write for the host port
`timescale 1ns/1ps
`include "sd_block_config.svh"

module card_ctrl (
	input  logic        clk,
	input  logic        reset,
	blk_cmd_if.card     cmd,
	sector_buf_if.card  buf_c,
	input  logic        sd_miso,
	output logic        sd_cs_n,
	output logic        sd_sclk,
	output logic        sd_mosi
);
	import sd_block_pkg::*;

	localparam logic [5:0] CMD_GO_IDLE   = 6'd0;
	localparam logic [5:0] CMD_SEND_OP   = 6'd1;
	localparam logic [5:0] CMD_SET_BLEN  = 6'd16;
	localparam logic [5:0] CMD_READ_BLK  = 6'd17;
	localparam logic [5:0] CMD_WRITE_BLK = 6'd24;
	localparam logic [7:0] LAST_WORD     = 8'(`SD_SECTOR_WORDS - 1);
	localparam logic [3:0] LAST_DUMMY    = 4'(`SD_DUMMY_BYTES - 1);

	card_state_t state;
	logic        pend;
	logic        go;
	logic        done;
	logic        byte_done;
	logic        fast;
	logic        cs_on;
	logic        inited;
	logic        err;
	logic        hi;
	logic [3:0]  bcnt;
	logic [7:0]  wc;
	logic [7:0]  tx;
	logic [7:0]  rx;
	logic [7:0]  lo_byte;
	logic [47:0] frame;
	logic [47:0] frame_sh;
	blk_op_t     op_q;
	logic [15:0] sector_q;

	function automatic logic [47:0] make_frame(input logic [5:0] idx, input logic [31:0] arg);
		logic [7:0] crc;
		// Only CMD0 needs a valid CRC in SPI mode
		crc = (idx == CMD_GO_IDLE) ? 8'h95 : 8'h01;
		return {2'b01, idx, arg, crc};
	endfunction

	// Standard capacity card, byte address is sector * 512
	function automatic logic [47:0] blk_frame(input blk_op_t op, input logic [15:0] sec);
		logic [5:0] idx;
		idx = (op == op_write) ? CMD_WRITE_BLK : CMD_READ_BLK;
		return make_frame(idx, {7'd0, sec, 9'd0});
	endfunction

	spi_byte_engine u_spi (
		.clk     (clk),
		.reset   (reset),
		.go      (go),
		.fast    (fast),
		.tx      (tx),
		.cs_on   (cs_on),
		.sd_miso (sd_miso),
		.rx      (rx),
		.done    (done),
		.sd_cs_n (sd_cs_n),
		.sd_sclk (sd_sclk),
		.sd_mosi (sd_mosi)
	);

	assign byte_done  = pend && done;
	assign frame_sh   = frame << {bcnt, 3'b000};
	assign cs_on      = !(state inside {st_idle, st_dummy, st_gap, st_done});
	assign cmd.busy   = (state != st_idle);
	assign cmd.err    = err;
	assign cmd.inited = inited;
	assign buf_c.c_addr = wc;

	// Byte to send in the current phase
	always_comb begin
		case (state)
			st_send_cmd: tx = frame_sh[47:40];
			st_wr_token: tx = TOKEN_START;
			st_wr_data:  tx = hi ? buf_c.c_rdata[15:8] : buf_c.c_rdata[7:0];
			st_wr_crc:   tx = 8'h00;
			default:     tx = 8'hFF;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= st_idle;
			pend       <= 1'b0;
			go         <= 1'b0;
			fast       <= 1'b0;
			inited     <= 1'b0;
			err        <= 1'b0;
			hi         <= 1'b0;
			bcnt       <= 4'd0;
			wc         <= 8'd0;
			buf_c.c_we <= 1'b0;
		end else begin
			go         <= 1'b0;
			buf_c.c_we <= 1'b0;
			// Step to the next word once a received word is stored
			if (buf_c.c_we)
				wc <= wc + 8'd1;
			// One byte in flight at a time in every active phase
			if (state != st_idle) begin
				if (!pend) begin
					go   <= 1'b1;
					pend <= 1'b1;
				end else if (done) begin
					pend <= 1'b0;
				end
			end
			case (state)
				st_idle: if (cmd.start) begin
					err      <= 1'b0;
					op_q     <= cmd.op;
					sector_q <= cmd.sector;
					bcnt     <= 4'd0;
					if (!(cmd.op inside {op_read, op_write}) || !inited) begin
						fast  <= 1'b0;
						state <= st_dummy;
					end else begin
						frame <= blk_frame(cmd.op, cmd.sector);
						state <= st_gap;
					end
				end
				st_dummy: if (byte_done) begin
					if (bcnt == LAST_DUMMY) begin
						bcnt  <= 4'd0;
						frame <= make_frame(CMD_GO_IDLE, 32'd0);
						state <= st_send_cmd;
					end else begin
						bcnt <= bcnt + 4'd1;
					end
				end
				st_gap: if (byte_done)
					state <= st_send_cmd;
				st_send_cmd: if (byte_done) begin
					if (bcnt == 4'd5) begin
						bcnt  <= 4'd0;
						state <= st_poll_r1;
					end else begin
						bcnt <= bcnt + 4'd1;
					end
				end
				st_poll_r1: if (byte_done && rx != 8'hFF) begin
					// Retry the same frame unless the R1 moves us on
					state <= st_gap;
					case (frame[45:40])
						CMD_GO_IDLE: if (rx == R1_IDLE)
							frame <= make_frame(CMD_SEND_OP, 32'd0);
						CMD_SEND_OP: if (rx == R1_READY) begin
							fast  <= 1'b1;
							frame <= make_frame(CMD_SET_BLEN, 32'd512);
						end
						CMD_SET_BLEN: if (rx == R1_READY) begin
							inited <= 1'b1;
							if (op_q inside {op_read, op_write})
								frame <= blk_frame(op_q, sector_q);
							else
								state <= st_done;
						end
						default: begin
							wc <= 8'd0;
							hi <= 1'b0;
							if (rx != R1_READY) begin
								err   <= 1'b1;
								state <= st_done;
							end else if (frame[45:40] == CMD_WRITE_BLK) begin
								state <= st_wr_token;
							end else begin
								state <= st_rd_token;
							end
						end
					endcase
				end
				st_rd_token: if (byte_done && rx == TOKEN_START)
					state <= st_rd_data;
				st_rd_data: if (byte_done) begin
					// Low byte first, word written after its high byte
					if (!hi) begin
						lo_byte <= rx;
						hi      <= 1'b1;
					end else begin
						hi            <= 1'b0;
						buf_c.c_we    <= 1'b1;
						buf_c.c_wdata <= {rx, lo_byte};
						if (wc == LAST_WORD)
							state <= st_rd_crc;
					end
				end
				st_rd_crc, st_wr_crc: if (byte_done) begin
					if (bcnt == 4'd1) begin
						bcnt  <= 4'd0;
						state <= (state == st_rd_crc) ? st_done : st_wr_dresp;
					end else begin
						bcnt <= bcnt + 4'd1;
					end
				end
				st_wr_token: if (byte_done)
					state <= st_wr_data;
				st_wr_data: if (byte_done) begin
					hi <= !hi;
					if (hi) begin
						wc <= wc + 8'd1;
						if (wc == LAST_WORD)
							state <= st_wr_crc;
					end
				end
				st_wr_dresp: if (byte_done && rx != 8'hFF) begin
					if (rx[4] || !rx[0] || rx[3:1] != DRESP_ACCEPTED)
						err <= 1'b1;
					state <= st_wr_busy;
				end
				// Card holds MISO low while programming
				st_wr_busy: if (byte_done && rx != 8'h00)
					state <= st_done;
				st_done: if (byte_done)
					state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* design/wb_host_regs.sv */
// Wishbone classic slave exposing control/status, sector address and the sector data port
`timescale 1ns/1ps
`include "sd_block_config.svh"

module wb_host_regs (
	input  logic        clk,
	input  logic        reset,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [15:0] wb_wdata,
	output logic [15:0] wb_rdata,
	output logic        wb_ack,
	blk_cmd_if.host     cmd,
	sector_buf_if.host  buf_h
);
	import sd_block_pkg::*;

	logic        req;
	logic        start_ok;
	logic        data_acc;
	logic [7:0]  ptr;
	logic        rd_data_sel;
	logic [15:0] status;

	// New request only when no ack is pending, so each ack is one cycle
	assign req      = wb_cyc && wb_stb && !wb_ack;
	assign start_ok = req && wb_we && (wb_adr == `SD_REG_CTRL) && !cmd.busy;
	assign data_acc = req && (wb_adr == `SD_REG_DATA);

	// Buffer address follows the word pointer
	assign buf_h.h_addr  = ptr;
	assign buf_h.h_wdata = wb_wdata;
	assign buf_h.h_we    = data_acc && wb_we && !cmd.busy;

	assign status   = {13'd0, cmd.inited, cmd.err, cmd.busy};
	// RAM data arrives in the ack cycle
	assign wb_rdata = rd_data_sel ? buf_h.h_rdata : status;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack      <= 1'b0;
			cmd.start   <= 1'b0;
			ptr         <= 8'd0;
			rd_data_sel <= 1'b0;
		end else begin
			wb_ack    <= req;
			cmd.start <= start_ok;
			if (req)
				rd_data_sel <= (wb_adr == `SD_REG_DATA);
			if (start_ok)
				ptr <= 8'd0;
			else if (data_acc)
				ptr <= ptr + 8'd1;
		end
	end

	// Command payload
	always_ff @(posedge clk) begin
		if (req && wb_we && (wb_adr == `SD_REG_ADDR))
			cmd.sector <= wb_wdata;
		if (start_ok)
			cmd.op <= blk_op_t'(wb_wdata[1:0]);
	end

endmodule

/* design/sd_block_dev_top.sv */
// SD/MMC block device top: Wishbone host port in, SPI card pins out
`timescale 1ns/1ps

module sd_block_dev_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [15:0] wb_wdata,
	input  logic        sd_miso,
	output logic [15:0] wb_rdata,
	output logic        wb_ack,
	output logic        sd_cs_n,
	output logic        sd_sclk,
	output logic        sd_mosi
);
	blk_cmd_if    cmd_link ();
	sector_buf_if buf_link ();

	wb_host_regs u_regs (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_wdata (wb_wdata),
		.wb_rdata (wb_rdata),
		.wb_ack   (wb_ack),
		.cmd      (cmd_link.host),
		.buf_h    (buf_link.host)
	);

	sector_buffer u_buf (
		.clk (clk),
		.mem (buf_link.mem)
	);

	card_ctrl u_card (
		.clk     (clk),
		.reset   (reset),
		.cmd     (cmd_link.card),
		.buf_c   (buf_link.card),
		.sd_miso (sd_miso),
		.sd_cs_n (sd_cs_n),
		.sd_sclk (sd_sclk),
		.sd_mosi (sd_mosi)
	);

endmodule

/* test/sd_card_model.sv */
// Behavioural SPI-mode SD card for the testbench; instantiate on the DUT's SPI pins
`timescale 1ns/1ps

module sd_card_model (
	input  logic sd_cs_n,
	input  logic sd_sclk,
	input  logic sd_mosi,
	output logic sd_miso
);
	import sd_block_pkg::*;

	// Byte address of sector 7, answered with an illegal command R1
	localparam logic [31:0] BAD_ADDR = 32'd3584;

	logic [7:0]  store [0:4095];
	logic [7:0]  resp [0:1023];
	logic [9:0]  wr_ptr = '0;
	logic [9:0]  rd_ptr = '0;
	logic [7:0]  in_sh = 8'hFF;
	logic [7:0]  out_sh = 8'hFF;
	logic [2:0]  bit_cnt = '0;
	logic [47:0] cmd_buf = '0;
	int          cmd_cnt = 0;
	int          op1_polls = 0;
	// 0 commands, 1 waiting for start token, 2 data and CRC
	int          wr_phase = 0;
	int          wr_cnt = 0;
	int          wr_base = 0;

	assign sd_miso = sd_cs_n ? 1'b1 : out_sh[7];

	initial begin
		for (int i = 0; i < 4096; i++)
			store[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
	end

	task automatic push_byte(input logic [7:0] b);
		resp[wr_ptr] = b;
		wr_ptr = wr_ptr + 10'd1;
	endtask

	task automatic do_command(input logic [47:0] f);
		logic [5:0]  idx;
		logic [31:0] arg;
		int          base;
		idx  = f[45:40];
		arg  = f[39:8];
		base = int'(arg[11:0]);
		case (idx)
			6'd0: begin
				op1_polls = 0;
				push_byte(R1_IDLE);
			end
			6'd1: begin
				// Ready on the third poll
				if (op1_polls < 2) begin
					op1_polls++;
					push_byte(R1_IDLE);
				end else begin
					push_byte(R1_READY);
				end
			end
			6'd16: push_byte(R1_READY);
			6'd17: begin
				if (arg == BAD_ADDR) begin
					push_byte(8'h04);
				end else begin
					push_byte(R1_READY);
					push_byte(TOKEN_START);
					for (int i = 0; i < 512; i++)
						push_byte(store[(base + i) & 4095]);
					push_byte(8'hFF);
					push_byte(8'hFF);
				end
			end
			6'd24: begin
				if (arg == BAD_ADDR) begin
					push_byte(8'h04);
				end else begin
					push_byte(R1_READY);
					wr_phase = 1;
					wr_base  = base;
				end
			end
			default: push_byte(8'h04);
		endcase
	endtask

	task automatic take_byte(input logic [7:0] b);
		if (wr_phase == 1) begin
			if (b == TOKEN_START) begin
				wr_phase = 2;
				wr_cnt   = 0;
			end
		end else if (wr_phase == 2) begin
			if (wr_cnt < 512)
				store[(wr_base + wr_cnt) & 4095] = b;
			wr_cnt++;
			// Data response, one busy byte, then idle
			if (wr_cnt == 514) begin
				push_byte(8'h05);
				push_byte(8'h00);
				wr_phase = 0;
			end
		end else if (cmd_cnt > 0 || b[7:6] == 2'b01) begin
			cmd_buf = {cmd_buf[39:0], b};
			cmd_cnt++;
			if (cmd_cnt == 6) begin
				cmd_cnt = 0;
				do_command(cmd_buf);
			end
		end
	endtask

	// MOSI sampled on the rising edge
	always @(posedge sd_sclk or posedge sd_cs_n) begin
		if (sd_cs_n) begin
			bit_cnt = 3'd0;
		end else begin
			in_sh   = {in_sh[6:0], sd_mosi};
			bit_cnt = bit_cnt + 3'd1;
			if (bit_cnt == 3'd0)
				take_byte(in_sh);
		end
	end

	// Next MISO bit on the falling edge, a new byte after the eighth
	always @(negedge sd_sclk or negedge sd_cs_n) begin
		if (!sd_cs_n) begin
			if (bit_cnt == 3'd0) begin
				if (rd_ptr != wr_ptr) begin
					out_sh = resp[rd_ptr];
					rd_ptr = rd_ptr + 10'd1;
				end else begin
					out_sh = 8'hFF;
				end
			end else begin
				out_sh = {out_sh[6:0], 1'b1};
			end
		end
	end

endmodule

/* test/sd_block_props.sv */
// Port-level protocol checks for the block device, bound to its top level
`timescale 1ns/1ps
`include "sd_block_config.svh"

module sd_block_props (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic sd_cs_n,
	input logic sd_sclk
);
	int   failures = 0;
	int   hi_edges;
	logic first_sel;
	logic sclk_q;

	// Rising SCLK edges seen while the card is deselected
	always_ff @(posedge clk) begin
		sclk_q <= sd_sclk;
		if (reset) begin
			hi_edges  <= 0;
			first_sel <= 1'b1;
		end else if (!sd_cs_n) begin
			hi_edges  <= 0;
			first_sel <= 1'b0;
		end else if (sd_sclk && !sclk_q) begin
			hi_edges <= hi_edges + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Wishbone ack
	//////////////////////////////////////////////////////////////////////
	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		!(wb_cyc && wb_stb) |=> !wb_ack)
		else begin failures++; $error("wb_ack without a request"); end

	ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack)
		else begin failures++; $error("wb_ack longer than one cycle"); end

	reset_idle: assert property (@(posedge clk)
		reset |=> (!wb_ack && sd_cs_n && !sd_sclk))
		else begin failures++; $error("ports not idle after reset"); end

	//////////////////////////////////////////////////////////////////////
	// SPI pins
	//////////////////////////////////////////////////////////////////////
	// Select only moves between bytes, with SCLK at rest
	cs_between_bytes: assert property (@(posedge clk) disable iff (reset)
		(sd_cs_n != $past(sd_cs_n)) |-> (!sd_sclk && !$past(sd_sclk)))
		else begin failures++; $error("chip select moved during a byte"); end

	dummy_before_select: assert property (@(posedge clk) disable iff (reset)
		(first_sel && $fell(sd_cs_n)) |-> (hi_edges >= 8 * `SD_DUMMY_BYTES))
		else begin failures++; $error("card selected before the dummy clocks"); end

endmodule

bind sd_block_dev_top sd_block_props u_props (
	.clk     (clk),
	.reset   (reset),
	.wb_cyc  (wb_cyc),
	.wb_stb  (wb_stb),
	.wb_ack  (wb_ack),
	.sd_cs_n (sd_cs_n),
	.sd_sclk (sd_sclk)
);

/* test/tb_sd_block_dev.sv */
// Simulation top that drives the SD block device over Wishbone against an SD card model and checks the results
`timescale 1ns/1ps
`include "sd_block_config.svh"

module tb_sd_block_dev;
	import sd_block_pkg::*;

	// Two inits near 22k cycles each, five sector transfers near 19k each, plus margin
	localparam int CYCLE_LIMIT = 200000;

	logic        clk;
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [1:0]  wb_adr;
	logic [15:0] wb_wdata;
	logic [15:0] wb_rdata;
	logic        wb_ack;
	logic        sd_cs_n;
	logic        sd_sclk;
	logic        sd_mosi;
	logic        sd_miso;
	logic [15:0] words [0:`SD_SECTOR_WORDS-1];
	logic [15:0] status;
	integer      seed;
	int          errors;
	int          checks;
	int          total;
	int          cycles = 0;

	sd_block_dev_top u_dut (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_wdata (wb_wdata),
		.sd_miso  (sd_miso),
		.wb_rdata (wb_rdata),
		.wb_ack   (wb_ack),
		.sd_cs_n  (sd_cs_n),
		.sd_sclk  (sd_sclk),
		.sd_mosi  (sd_mosi)
	);

	sd_card_model u_card_model (
		.sd_cs_n (sd_cs_n),
		.sd_sclk (sd_sclk),
		.sd_mosi (sd_mosi),
		.sd_miso (sd_miso)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: no result after %0d clock cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("** Error at %0t: %s got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Wishbone access
	//////////////////////////////////////////////////////////////////////
	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [15:0] wdata,
		output logic [15:0] rdata);
		@(posedge clk);
		#1;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_wdata = wdata;
		do begin
			@(posedge clk);
			#1;
		end while (!wb_ack);
		rdata = wb_rdata;
		// Classic master drops the strobe after the edge that samples ack
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic reg_write(input logic [1:0] adr, input logic [15:0] data);
		logic [15:0] unused;
		wb_access(1'b1, adr, data, unused);
	endtask

	task automatic reg_read(input logic [1:0] adr, output logic [15:0] data);
		wb_access(1'b0, adr, 16'd0, data);
	endtask

	task automatic wait_idle(output logic [15:0] st);
		do
			reg_read(`SD_REG_CTRL, st);
		while (st[0]);
	endtask

	task automatic run_cmd(input blk_op_t op, input logic [15:0] sector, output logic [15:0] st);
		reg_write(`SD_REG_ADDR, sector);
		reg_write(`SD_REG_CTRL, {14'd0, op});
		wait_idle(st);
	endtask

	task automatic fill_buffer();
		int i;
		for (i = 0; i < `SD_SECTOR_WORDS; i++) begin
			words[i] = 16'($random(seed));
			reg_write(`SD_REG_DATA, words[i]);
		end
	endtask

	task automatic check_buffer(input string tag);
		logic [15:0] rd;
		int          i;
		for (i = 0; i < `SD_SECTOR_WORDS; i++) begin
			reg_read(`SD_REG_DATA, rd);
			check_value(rd, words[i], $sformatf("%s word %0d", tag, i));
		end
	endtask

	// Card store is byte addressed with the low byte of each word first
	task automatic check_store(input int sector);
		int base;
		int i;
		base = sector * 512;
		for (i = 0; i < `SD_SECTOR_WORDS; i++)
			check_value({u_card_model.store[base + 2*i + 1], u_card_model.store[base + 2*i]},
				words[i], $sformatf("card byte pair %0d", i));
	endtask

	initial begin
		clk      = 1'b0;
		reset    = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 2'd0;
		wb_wdata = 16'd0;
		seed     = 32'h45ad5158;
		errors   = 0;
		checks   = 0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		// Idle state after reset
		check_value({15'd0, sd_cs_n}, 16'd1, "chip select after reset");
		check_value({15'd0, sd_sclk}, 16'd0, "sclk after reset");
		reg_read(`SD_REG_CTRL, status);
		check_value(status, 16'h0000, "status after reset");

		// Write on a fresh card runs the card reset first
		fill_buffer();
		run_cmd(op_write, 16'd3, status);
		check_value(status, 16'h0004, "status after first write");
		check_store(3);

		run_cmd(op_read, 16'd3, status);
		check_value(status, 16'h0004, "status after read");
		check_buffer("read sector 3");

		// Rejected read followed by a recovery read
		run_cmd(op_read, 16'd7, status);
		check_value(status, 16'h0006, "status after bad read");
		run_cmd(op_read, 16'd3, status);
		check_value(status, 16'h0004, "status after recovery read");
		check_buffer("recovery read");

		run_cmd(op_init, 16'd0, status);
		check_value(status, 16'h0004, "status after explicit init");

		// Buffer writes while the card side streams must be dropped
		reg_write(`SD_REG_ADDR, 16'd3);
		reg_write(`SD_REG_CTRL, {14'd0, op_write});
		repeat (8) reg_write(`SD_REG_DATA, 16'hDEAD);
		wait_idle(status);
		check_value(status, 16'h0004, "status after busy write");
		check_store(3);
		run_cmd(op_read, 16'd3, status);
		check_buffer("reread sector 3");

		total = errors + u_dut.u_props.failures;
		$display("Summary: %0d checks, %0d check errors, %0d property failures",
			checks, errors, u_dut.u_props.failures);
		if (total == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* sd_block_dev.f */
+incdir+design
design/sd_block_pkg.sv
design/sd_block_if.sv
design/sector_buffer.sv
design/spi_byte_engine.sv
design/card_ctrl.sv
design/wb_host_regs.sv
design/sd_block_dev_top.sv
test/sd_card_model.sv
test/sd_block_props.sv
test/tb_sd_block_dev.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the block device testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_sd_block_dev \
	-f sd_block_dev.f -o tb_sim \
	&& ./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
[ -s sim.log ] && ! grep -q "TEST FAILED" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
